//--- Bender.yml
package:
  name: huf_comp

sources:
  - files:
      - logic/huf_comp_pkg.sv
      - logic/huf_code_table.sv
      - logic/huf_lut_pair.sv
      - logic/huf_sym_frontend.sv
      - logic/huf_bit_packer.sv
      - logic/huf_comp_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/huf_comp_tb.sv

//--- logic/huf_bit_packer.sv
// packs variable length codes MSB first into 16-bit words sent under output credits
module huf_bit_packer
   import huf_comp_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,

   // items from the table pair
   input  logic               pk_valid,
   input  logic [CODE_W-1:0]  pk_code,
   input  logic [LEN_W-1:0]   pk_len,
   input  item_op_e           pk_op,
   output logic               pk_credit,

   // packed word stream
   input  logic               out_credit,
   output logic               out_valid,
   output logic [WORD_W-1:0]  out_data,
   output logic               out_last,
   output logic [NBITS_W-1:0] out_nbits
);

   logic [CODE_W-1:0]     code_mem [PACK_CREDITS];
   logic [LEN_W-1:0]      len_mem  [PACK_CREDITS];
   item_op_e              op_mem   [PACK_CREDITS];
   logic [PACK_PTR_W-1:0] wr_ptr;
   logic [PACK_PTR_W-1:0] rd_ptr;
   logic [CRED_W-1:0]     buf_cnt;
   logic [CRED_W-1:0]     out_cred;
   logic [ACC_W-1:0]      acc;         // valid bits from the top, zeros below
   logic [ACC_W-1:0]      acc_sh;
   logic [NBITS_W-1:0]    fill;
   logic [NBITS_W-1:0]    fill_sh;
   logic [NBITS_W-1:0]    al_sh;
   logic [CODE_W-1:0]     head_code;
   logic                  flush_pend;
   logic                  emit_full;
   logic                  emit_part;
   logic                  word_last;
   logic                  flush_clr;
   logic                  pop;

   // **************************************************
   // emit and pop decisions
   // **************************************************
   always_comb begin
      emit_full = (fill >= NBITS_W'(WORD_W)) && (out_cred != '0);
      emit_part = flush_pend && (fill < NBITS_W'(WORD_W)) && (fill != '0) &&
                  (out_cred != '0);
      word_last = emit_part || (emit_full && flush_pend && (fill == NBITS_W'(WORD_W)));
      flush_clr = word_last || (flush_pend && (fill == '0));

      if (emit_full) begin
         acc_sh  = acc << WORD_W;
         fill_sh = fill - NBITS_W'(WORD_W);
      end else if (emit_part) begin
         acc_sh  = '0;
         fill_sh = '0;
      end else begin
         acc_sh  = acc;
         fill_sh = fill;
      end

      // a 15-bit code always fits once at most 16 bits remain
      pop       = !flush_pend && (buf_cnt != '0) && (fill_sh <= NBITS_W'(WORD_W));
      head_code = code_mem[rd_ptr] & ~({CODE_W{1'b1}} << len_mem[rd_ptr]);
      al_sh     = NBITS_W'(ACC_W) - fill_sh - NBITS_W'(len_mem[rd_ptr]);
   end

   always_ff @(posedge clk) begin
      if (pk_valid) begin
         code_mem[wr_ptr] <= pk_code;
         len_mem[wr_ptr]  <= pk_len;
         op_mem[wr_ptr]   <= pk_op;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         buf_cnt    <= '0;
         out_cred   <= CRED_W'(OUT_CREDITS);
         acc        <= '0;
         fill       <= '0;
         flush_pend <= 1'b0;
         pk_credit  <= 1'b0;
         out_valid  <= 1'b0;
      end else begin
         if (pk_valid) wr_ptr <= wr_ptr + 1'b1;
         if (pop) rd_ptr <= rd_ptr + 1'b1;
         case ({pk_valid, pop})
            2'b10:   buf_cnt <= buf_cnt + 1'b1;
            2'b01:   buf_cnt <= buf_cnt - 1'b1;
            default: buf_cnt <= buf_cnt;
         endcase
         case ({emit_full || emit_part, out_credit})
            2'b10:   out_cred <= out_cred - 1'b1;
            2'b01:   out_cred <= out_cred + 1'b1;
            default: out_cred <= out_cred;
         endcase
         if (pop) begin
            acc  <= acc_sh | (ACC_W'(head_code) << al_sh);
            fill <= fill_sh + NBITS_W'(len_mem[rd_ptr]);
         end else begin
            acc  <= acc_sh;
            fill <= fill_sh;
         end
         if (pop && (op_mem[rd_ptr] == OP_FLUSH)) flush_pend <= 1'b1;
         else if (flush_clr) flush_pend <= 1'b0;
         pk_credit <= pop;
         out_valid <= emit_full || emit_part;
      end
   end

   // **************************************************
   // output word
   // **************************************************
   always_ff @(posedge clk) begin
      if (emit_full || emit_part) begin
         out_data  <= acc[ACC_W-1 -: WORD_W];   // partial words carry zero padding
         out_last  <= word_last;
         out_nbits <= emit_full ? NBITS_W'(WORD_W) : fill;
      end
   end

endmodule

//--- logic/huf_code_table.sv
// one code table bank holding code and length per symbol; instanced twice by huf_lut_pair
module huf_code_table
   import huf_comp_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,

   // fill side
   input  logic              wr,
   input  logic [SYM_W-1:0]  wr_sym,
   input  logic [CODE_W-1:0] wr_code,
   input  logic [LEN_W-1:0]  wr_len,
   input  logic              wr_done,
   input  logic              rel,

   // lookup side
   input  logic              rd,
   input  logic [SYM_W-1:0]  rd_sym,

   output tbl_state_e        state,
   output logic [CODE_W-1:0] rd_code,
   output logic [LEN_W-1:0]  rd_len
);

   logic [CODE_W-1:0] code_mem [NUM_SYMS];
   logic [LEN_W-1:0]  len_mem  [NUM_SYMS];
   logic              wr_ok;

   // a bank in use by the compressor is locked against writes
   assign wr_ok = wr && (state == TBL_FREE);

   // **************************************************
   // bank state
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= TBL_FREE;
      end else if (rel) begin
         state <= TBL_FREE;          // block done with this bank
      end else if (wr_done) begin
         state <= TBL_READY;
      end
   end

   // **************************************************
   // storage
   // **************************************************
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         code_mem[wr_sym] <= wr_code;
         len_mem[wr_sym]  <= wr_len;
      end
   end

   // registered read, data valid the cycle after rd
   always_ff @(posedge clk) begin
      if (rd) begin
         rd_code <= code_mem[rd_sym];
         rd_len  <= len_mem[rd_sym];
      end
   end

endmodule

//--- logic/huf_comp_pkg.sv
// widths, credit counts and enums shared by the huffman back end; import with huf_comp_pkg::*
package huf_comp_pkg;

   // **************************************************
   // symbol and code sizes
   // **************************************************
   localparam int SYM_W    = 8;        // literal symbol
   localparam int NUM_SYMS = 256;      // entries per table bank
   localparam int CODE_W   = 15;       // longest code
   localparam int LEN_W    = 4;        // code length, 0 marks an unused entry

   // **************************************************
   // packed output
   // **************************************************
   localparam int WORD_W  = 16;
   localparam int NBITS_W = 5;         // valid bits of a word, 1..16
   localparam int ACC_W   = 2*WORD_W - 1;

   // **************************************************
   // credits and buffer depths
   // **************************************************
   localparam int SYM_CREDITS  = 4;    // front end buffer depth
   localparam int PACK_CREDITS = 2;    // packer input buffer depth
   localparam int OUT_CREDITS  = 4;    // downstream words after reset
   localparam int CRED_W       = 3;

   localparam int SYM_PTR_W  = $clog2(SYM_CREDITS);
   localparam int PACK_PTR_W = $clog2(PACK_CREDITS);

   // bank ownership, free banks take writes and ready banks serve lookups
   typedef enum logic {
      TBL_FREE  = 1'b0,
      TBL_READY = 1'b1
   } tbl_state_e;

   // item from the front end to the packer
   typedef enum logic {
      OP_CODE  = 1'b0,   // append the code
      OP_FLUSH = 1'b1    // append the code, then close the block
   } item_op_e;

endpackage

//--- logic/huf_comp_top.sv
// top level of the huffman back end, front end into table pair into bit packer
module huf_comp_top
   import huf_comp_pkg::*;
(
   input  logic               clk,
   input  logic               rst_n,

   // table fill
   input  logic               tbl_wr,
   input  logic               tbl_wr_bank,
   input  logic [SYM_W-1:0]   tbl_wr_sym,
   input  logic [CODE_W-1:0]  tbl_wr_code,
   input  logic [LEN_W-1:0]   tbl_wr_len,
   input  logic               tbl_wr_done,
   output logic [1:0]         bank_full,

   // symbols in
   input  logic               sym_valid,
   input  logic [SYM_W-1:0]   sym_data,
   input  logic               sym_last,
   output logic               sym_credit,

   // words out
   input  logic               out_credit,
   output logic               out_valid,
   output logic [WORD_W-1:0]  out_data,
   output logic               out_last,
   output logic [NBITS_W-1:0] out_nbits
);

   logic              lk_valid;
   logic              lk_bank;
   logic [SYM_W-1:0]  lk_sym;
   item_op_e          lk_op;
   logic              rel_valid;
   logic              rel_bank;
   logic              pk_valid;
   logic [CODE_W-1:0] pk_code;
   logic [LEN_W-1:0]  pk_len;
   item_op_e          pk_op;
   logic              pk_credit;

   huf_sym_frontend huf_sym_frontend_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .sym_valid  (sym_valid),
      .sym_data   (sym_data),
      .sym_last   (sym_last),
      .sym_credit (sym_credit),
      .bank_full  (bank_full),
      .pk_credit  (pk_credit),
      .lk_valid   (lk_valid),
      .lk_bank    (lk_bank),
      .lk_sym     (lk_sym),
      .lk_op      (lk_op),
      .rel_valid  (rel_valid),
      .rel_bank   (rel_bank)
   );

   huf_lut_pair huf_lut_pair_i (
      .clk         (clk),
      .rst_n       (rst_n),
      .tbl_wr      (tbl_wr),
      .tbl_wr_bank (tbl_wr_bank),
      .tbl_wr_sym  (tbl_wr_sym),
      .tbl_wr_code (tbl_wr_code),
      .tbl_wr_len  (tbl_wr_len),
      .tbl_wr_done (tbl_wr_done),
      .bank_full   (bank_full),
      .lk_valid    (lk_valid),
      .lk_bank     (lk_bank),
      .lk_sym      (lk_sym),
      .lk_op       (lk_op),
      .rel_valid   (rel_valid),
      .rel_bank    (rel_bank),
      .pk_valid    (pk_valid),
      .pk_code     (pk_code),
      .pk_len      (pk_len),
      .pk_op       (pk_op)
   );

   huf_bit_packer huf_bit_packer_i (
      .clk        (clk),
      .rst_n      (rst_n),
      .pk_valid   (pk_valid),
      .pk_code    (pk_code),
      .pk_len     (pk_len),
      .pk_op      (pk_op),
      .pk_credit  (pk_credit),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_last   (out_last),
      .out_nbits  (out_nbits)
   );

endmodule

//--- logic/huf_lut_pair.sv
// ping-pong pair of code table banks behind one lookup port; feeds items to the bit packer
module huf_lut_pair
   import huf_comp_pkg::*;
(
   input  logic              clk,
   input  logic              rst_n,

   // table fill from software
   input  logic              tbl_wr,
   input  logic              tbl_wr_bank,
   input  logic [SYM_W-1:0]  tbl_wr_sym,
   input  logic [CODE_W-1:0] tbl_wr_code,
   input  logic [LEN_W-1:0]  tbl_wr_len,
   input  logic              tbl_wr_done,
   output logic [1:0]        bank_full,

   // lookup from the front end
   input  logic              lk_valid,
   input  logic              lk_bank,
   input  logic [SYM_W-1:0]  lk_sym,
   input  item_op_e          lk_op,
   input  logic              rel_valid,
   input  logic              rel_bank,

   // item to the packer
   output logic              pk_valid,
   output logic [CODE_W-1:0] pk_code,
   output logic [LEN_W-1:0]  pk_len,
   output item_op_e          pk_op
);

   tbl_state_e        bank_state [2];
   logic [CODE_W-1:0] bank_code  [2];
   logic [LEN_W-1:0]  bank_len   [2];
   logic              sel_q;           // bank read last cycle

   for (genvar b = 0; b < 2; b++) begin : g_bank
      huf_code_table huf_code_table_i (
         .clk     (clk),
         .rst_n   (rst_n),
         .wr      (tbl_wr && (tbl_wr_bank == 1'(b))),
         .wr_sym  (tbl_wr_sym),
         .wr_code (tbl_wr_code),
         .wr_len  (tbl_wr_len),
         .wr_done (tbl_wr_done && (tbl_wr_bank == 1'(b))),
         .rel     (rel_valid && (rel_bank == 1'(b))),
         .rd      (lk_valid && (lk_bank == 1'(b))),
         .rd_sym  (lk_sym),
         .state   (bank_state[b]),
         .rd_code (bank_code[b]),
         .rd_len  (bank_len[b])
      );

      assign bank_full[b] = (bank_state[b] == TBL_READY);
   end

   // **************************************************
   // one cycle alongside the bank read
   // **************************************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pk_valid <= 1'b0;
      end else begin
         pk_valid <= lk_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (lk_valid) begin
         sel_q <= lk_bank;
         pk_op <= lk_op;
      end
   end

   assign pk_code = bank_code[sel_q];
   assign pk_len  = bank_len[sel_q];

endmodule

//--- logic/huf_sym_frontend.sv
// symbol input buffer with credit return, active bank pointer and packer credit count
module huf_sym_frontend
   import huf_comp_pkg::*;
(
   input  logic             clk,
   input  logic             rst_n,

   // symbol stream, sender spends one credit per symbol
   input  logic             sym_valid,
   input  logic [SYM_W-1:0] sym_data,
   input  logic             sym_last,
   output logic             sym_credit,

   input  logic [1:0]       bank_full,
   input  logic             pk_credit,

   // lookup into the table pair
   output logic             lk_valid,
   output logic             lk_bank,
   output logic [SYM_W-1:0] lk_sym,
   output item_op_e         lk_op,
   output logic             rel_valid,
   output logic             rel_bank
);

   logic [SYM_W-1:0]     sym_mem  [SYM_CREDITS];
   logic                 last_mem [SYM_CREDITS];
   logic [SYM_PTR_W-1:0] wr_ptr;
   logic [SYM_PTR_W-1:0] rd_ptr;
   logic [CRED_W-1:0]    buf_cnt;
   logic [CRED_W-1:0]    pk_cred;
   logic                 act_bank;
   logic                 head_last;
   logic                 issue;

   // **************************************************
   // issue rule
   // **************************************************
   assign head_last = last_mem[rd_ptr];
   assign issue     = (buf_cnt != '0) && (pk_cred != '0) && bank_full[act_bank];

   assign sym_credit = issue;          // slot freed as the symbol leaves
   assign lk_valid   = issue;
   assign lk_bank    = act_bank;
   assign lk_sym     = sym_mem[rd_ptr];
   assign lk_op      = head_last ? OP_FLUSH : OP_CODE;
   assign rel_valid  = issue && head_last;
   assign rel_bank   = act_bank;

   always_ff @(posedge clk) begin
      if (sym_valid) begin
         sym_mem[wr_ptr]  <= sym_data;
         last_mem[wr_ptr] <= sym_last;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         buf_cnt  <= '0;
         pk_cred  <= CRED_W'(PACK_CREDITS);
         act_bank <= 1'b0;
      end else begin
         if (sym_valid) wr_ptr <= wr_ptr + 1'b1;
         if (issue) rd_ptr <= rd_ptr + 1'b1;
         case ({sym_valid, issue})
            2'b10:   buf_cnt <= buf_cnt + 1'b1;
            2'b01:   buf_cnt <= buf_cnt - 1'b1;
            default: buf_cnt <= buf_cnt;
         endcase
         case ({issue, pk_credit})
            2'b10:   pk_cred <= pk_cred - 1'b1;
            2'b01:   pk_cred <= pk_cred + 1'b1;
            default: pk_cred <= pk_cred;
         endcase
         if (rel_valid) act_bank <= ~act_bank;   // next block uses the other bank
      end
   end

endmodule

//--- sim.f
+incdir+testbench
logic/huf_comp_pkg.sv
logic/huf_code_table.sv
logic/huf_lut_pair.sv
logic/huf_sym_frontend.sv
logic/huf_bit_packer.sv
logic/huf_comp_top.sv
testbench/huf_comp_tb.sv

//--- testbench/huf_comp_model.svh
// reference model for the huffman back end testbench; included inside the testbench module
`ifndef HUF_COMP_MODEL_SVH
`define HUF_COMP_MODEL_SVH

logic [31:0]       stim_lfsr = 32'hc5d8718e;   // tables, blocks and table writes
logic [31:0]       crd_lfsr  = 32'hc5d8718e;   // output credit pattern

// shadow copy of what each bank should hold
logic [CODE_W-1:0] shadow_code [2][NUM_SYMS];
logic [LEN_W-1:0]  shadow_len  [2][NUM_SYMS];

logic [SYM_W-1:0]  blk_sym  [$];               // symbols of the current block
logic              exp_bits [$];               // expected bit stream, oldest first

// fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic int unsigned take_bits(inout logic [31:0] st, input int n);
   int unsigned v;
   v = 0;
   for (int i = 0; i < n; i++) begin
      st = {st[30:0], st[31] ^ st[21] ^ st[1] ^ st[0]};
      v  = (v << 1) | st[0];
   end
   return v;
endfunction

// each code goes out from bit len-1 down to bit 0
function automatic void build_expected(input int bank);
   int len;
   exp_bits.delete();
   foreach (blk_sym[i]) begin
      len = shadow_len[bank][blk_sym[i]];
      for (int j = len - 1; j >= 0; j--) begin
         exp_bits.push_back(shadow_code[bank][blk_sym[i]][j]);
      end
   end
endfunction

// next word of the block, MSB first, zeros below the last valid bit
function automatic void next_expected(output logic [WORD_W-1:0] data,
                                      output int nbits, output logic last);
   data  = '0;
   nbits = 0;
   while ((nbits < WORD_W) && (exp_bits.size() > 0)) begin
      data[WORD_W-1-nbits] = exp_bits.pop_front();
      nbits++;
   end
   last = (exp_bits.size() == 0);
endfunction

`endif

//--- testbench/huf_comp_tb.sv
// testbench for huf_comp_top; random tables and blocks on ping-pong banks under credit back-pressure
module huf_comp_tb
   import huf_comp_pkg::*;
();

   localparam int NUM_BLOCKS = 40;
   localparam int TIMEOUT    = 2000;   // cycles per wait
   localparam int LATE_WAIT  = 24;     // idle cycles before a late table load

   logic               clk;
   logic               rst_n;
   logic               tbl_wr;
   logic               tbl_wr_bank;
   logic [SYM_W-1:0]   tbl_wr_sym;
   logic [CODE_W-1:0]  tbl_wr_code;
   logic [LEN_W-1:0]   tbl_wr_len;
   logic               tbl_wr_done;
   logic [1:0]         bank_full;
   logic               sym_valid;
   logic [SYM_W-1:0]   sym_data;
   logic               sym_last;
   logic               sym_credit;
   logic               out_credit;
   logic               out_valid;
   logic [WORD_W-1:0]  out_data;
   logic               out_last;
   logic [NBITS_W-1:0] out_nbits;

   int                 sym_sent     = 0;
   int                 sym_returned = 0;
   int                 out_owed     = 0;   // words received whose credit is not yet returned
   int                 word_errs    = 0;
   int                 credit_errs  = 0;
   int                 bank_errs    = 0;
   logic               loaded [2];
   logic [WORD_W-1:0]  got_data  [$];
   logic [NBITS_W-1:0] got_nbits [$];
   logic               got_last  [$];

   `include "huf_comp_model.svh"

   huf_comp_top huf_comp_top_i (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // **************************************************
   // output monitor and credit return
   // **************************************************
   initial begin
      out_credit = 1'b0;
      forever begin
         @(negedge clk);
         if (out_valid) begin
            got_data.push_back(out_data);
            got_nbits.push_back(out_nbits);
            got_last.push_back(out_last);
            out_owed++;
            if (out_owed > OUT_CREDITS) begin
               credit_errs++;
               $display("error %0t: %0d words out on %0d credits", $time, out_owed, OUT_CREDITS);
            end
         end
         if (sym_credit) begin
            if (sym_returned >= sym_sent) begin
               credit_errs++;
               $display("error %0t: sym_credit with no symbol outstanding", $time);
            end
            sym_returned <= sym_returned + 1;   // seen by the sender next cycle
         end
         if ((out_owed > 0) && (take_bits(crd_lfsr, 2) == 0)) begin
            out_credit = 1'b1;
            out_owed--;
         end else begin
            out_credit = 1'b0;
         end
      end
   end

   task automatic timeout_fail(input string what);
      $display("timeout: no %s within %0d cycles", what, TIMEOUT);
      $display("=== FAIL ===");
      $finish;
   endtask

   task automatic load_bank(input int bank);
      for (int s = 0; s < NUM_SYMS; s++) begin
         tbl_wr      = 1'b1;
         tbl_wr_bank = bank[0];
         tbl_wr_sym  = SYM_W'(s);
         tbl_wr_code = CODE_W'(take_bits(stim_lfsr, CODE_W));
         tbl_wr_len  = LEN_W'(take_bits(stim_lfsr, LEN_W));
         if (tbl_wr_len == '0) tbl_wr_len = LEN_W'(CODE_W);   // lengths 1..15
         shadow_code[bank][s] = tbl_wr_code;
         shadow_len[bank][s]  = tbl_wr_len;
         @(negedge clk);
      end
      tbl_wr      = 1'b0;
      tbl_wr_done = 1'b1;
      @(negedge clk);
      tbl_wr_done  = 1'b0;
      loaded[bank] = 1'b1;
   endtask

   // block already queued on an empty bank must not move
   task automatic late_load(input int bank);
      repeat (LATE_WAIT) begin
         @(negedge clk);
         if (sym_credit || out_valid) begin
            bank_errs++;
            $display("error %0t: block ran before bank %0d was loaded", $time, bank);
         end
      end
      load_bank(bank);
   endtask

   // writes into a bank in use leave the shadow unchanged
   task automatic poke_locked(input int bank);
      logic [SYM_W-1:0] s;
      repeat (4) begin
         s           = blk_sym[take_bits(stim_lfsr, 5) % blk_sym.size()];
         tbl_wr      = bank_full[bank];
         tbl_wr_bank = bank[0];
         tbl_wr_sym  = s;
         tbl_wr_code = ~shadow_code[bank][s];
         tbl_wr_len  = LEN_W'(16 - shadow_len[bank][s]);
         @(negedge clk);
      end
      tbl_wr = 1'b0;
   endtask

   task automatic send_block();
      int wait_cyc;
      foreach (blk_sym[i]) begin
         wait_cyc = 0;
         while (sym_sent - sym_returned >= SYM_CREDITS) begin
            sym_valid = 1'b0;
            @(negedge clk);
            wait_cyc++;
            if (wait_cyc > TIMEOUT) timeout_fail("symbol credit");
         end
         sym_valid = 1'b1;
         sym_data  = blk_sym[i];
         sym_last  = (i == blk_sym.size() - 1);
         sym_sent <= sym_sent + 1;   // counted once the symbol is on the bus
         @(negedge clk);
      end
      sym_valid = 1'b0;
      sym_last  = 1'b0;
   endtask

   task automatic collect_block(input int bank);
      logic [WORD_W-1:0] exp_data;
      int                exp_nbits;
      logic              exp_last;
      logic [WORD_W-1:0] data;
      logic [NBITS_W-1:0] nbits;
      logic              last;
      int                wait_cyc;
      logic              done;
      wait_cyc = 0;
      while (!bank_full[bank]) begin
         @(negedge clk);
         wait_cyc++;
         if (wait_cyc > TIMEOUT) timeout_fail("ready bank");
      end
      build_expected(bank);
      done = 1'b0;
      while (!done) begin
         wait_cyc = 0;
         while (got_data.size() == 0) begin
            @(negedge clk);
            wait_cyc++;
            if (wait_cyc > TIMEOUT) timeout_fail("output word");
         end
         next_expected(exp_data, exp_nbits, exp_last);
         data  = got_data.pop_front();
         nbits = got_nbits.pop_front();
         last  = got_last.pop_front();
         if ((data !== exp_data) || (int'(nbits) != exp_nbits) || (last !== exp_last)) begin
            word_errs++;
            $display("error %0t: bank %0d word %h/%0d/%b, expected %h/%0d/%b", $time, bank,
                     data, nbits, last, exp_data, exp_nbits, exp_last);
         end
         done = last || exp_last;
      end
   endtask

   // **************************************************
   // main sequence
   // **************************************************
   initial begin
      int   b;
      int   blk_len;
      int   wait_cyc;
      logic late;
      logic conc;
      rst_n       = 1'b0;
      tbl_wr      = 1'b0;
      tbl_wr_bank = 1'b0;
      tbl_wr_sym  = '0;
      tbl_wr_code = '0;
      tbl_wr_len  = '0;
      tbl_wr_done = 1'b0;
      sym_valid   = 1'b0;
      sym_data    = '0;
      sym_last    = 1'b0;
      loaded[0]   = 1'b0;
      loaded[1]   = 1'b0;
      repeat (5) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      for (int k = 0; k < NUM_BLOCKS; k++) begin
         b       = k % 2;
         late    = !loaded[b];
         conc    = late || (take_bits(stim_lfsr, 2) != 0);   // else the next block waits
         blk_len = 1 + take_bits(stim_lfsr, 5);
         blk_sym.delete();
         repeat (blk_len) blk_sym.push_back(SYM_W'(take_bits(stim_lfsr, SYM_W)));
         fork
            send_block();
            collect_block(b);
            begin
               if (late) late_load(b);
               if (conc) begin
                  poke_locked(b);
                  load_bank(1 - b);
               end
            end
         join
         if (bank_full[b] || (bank_full[1-b] != loaded[1-b])) begin
            bank_errs++;
            $display("error %0t: bank_full %b after block %0d on bank %0d", $time,
                     bank_full, k, b);
         end
         if (got_data.size() != 0) begin
            word_errs++;
            $display("error %0t: %0d extra words after block %0d", $time, got_data.size(), k);
            got_data.delete();
            got_nbits.delete();
            got_last.delete();
         end
         loaded[b] = 1'b0;
      end
      wait_cyc = 0;
      while (out_owed != 0) begin
         @(negedge clk);
         wait_cyc++;
         if (wait_cyc > TIMEOUT) timeout_fail("output credit return");
      end
      if (sym_sent != sym_returned) begin
         credit_errs++;
         $display("error %0t: %0d symbols sent, %0d credits back", $time, sym_sent, sym_returned);
      end
      $display("errors: %0d word, %0d credit, %0d bank", word_errs, credit_errs, bank_errs);
      if (word_errs + credit_errs + bank_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule
